//--- src/keypad_pkg.sv
package keypad_pkg;

    // one scanned key, either as a whole byte or as its two line fields
    typedef struct packed {
        logic [3:0] row; // active low, one bit per keypad row
        logic [3:0] col; // active low, the column driven when seen
    } key_coord_t;

    typedef union packed {
        logic [7:0] raw;
        key_coord_t coord;
    } key_code_t;

    // key codes in {row, col} form, as seen on the 4x4 matrix
    localparam logic [7:0] KEY_0         = 8'b0111_1101;
    localparam logic [7:0] KEY_1         = 8'b1110_1110;
    localparam logic [7:0] KEY_2         = 8'b1110_1101;
    localparam logic [7:0] KEY_3         = 8'b1110_1011;
    localparam logic [7:0] KEY_4         = 8'b1101_1110;
    localparam logic [7:0] KEY_5         = 8'b1101_1101;
    localparam logic [7:0] KEY_6         = 8'b1101_1011;
    localparam logic [7:0] KEY_7         = 8'b1011_1110;
    localparam logic [7:0] KEY_8         = 8'b1011_1101;
    localparam logic [7:0] KEY_9         = 8'b1011_1011;
    localparam logic [7:0] KEY_BACKSPACE = 8'b0111_1110; // '*' drops the last digit
    localparam logic [7:0] KEY_ENTER     = 8'b0111_1011; // '#' confirms the number
    localparam logic [7:0] KEY_PAUSE     = 8'b1110_0111; // 'A' pause / resume
    localparam logic [7:0] KEY_TOGGLE    = 8'b1101_0111; // 'B' keypad <-> switches
    localparam logic [7:0] KEY_C         = 8'b1011_0111;
    localparam logic [7:0] KEY_D         = 8'b0111_0111;

    localparam logic [7:0] KEY_NONE      = 8'hFF; // no row low, no key

    typedef enum logic [1:0] {
        ST_BLOCK  = 2'b00,
        ST_SWITCH = 2'b01,
        ST_KEYPAD = 2'b10,
        ST_HALT   = 2'b11
    } input_state_t;

endpackage

//--- src/keypad_scanner.sv
module keypad_scanner #(
    parameter int SCAN_DIV        = 2,
    parameter int DEBOUNCE_CYCLES = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [3:0]            row,
    output logic [3:0]            col,
    output keypad_pkg::key_code_t key_coord
);
    import keypad_pkg::*;

    localparam int DIV_W = $clog2(SCAN_DIV + 1);
    localparam int DEB_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [DIV_W-1:0] div_cnt;
    logic [3:0]       row_q;
    logic             sample;
    key_code_t        seen;
    key_code_t        cand;
    logic [DEB_W-1:0] hits;
    logic [DEB_W-1:0] hits_next;
    logic [1:0]       idle_cols;
    logic             armed;
    logic             fire;

    // row is registered once, so a column must be held for at least two cycles
    always_ff @(posedge clk) begin
        row_q <= row;
    end

    assign sample = (div_cnt == DIV_W'(SCAN_DIV - 1)); // last cycle of this column

    always_comb begin
        seen.coord.row = row_q;
        seen.coord.col = col;
    end

    assign hits_next = (seen.raw == cand.raw) ? hits + 1'b1 : DEB_W'(1);
    assign fire = sample && armed && (row_q != 4'hF) && (hits_next == DEB_W'(DEBOUNCE_CYCLES));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt   <= '0;
            col       <= 4'b1110; // column 0 first
            cand      <= KEY_NONE;
            hits      <= '0;
            idle_cols <= '0;
            armed     <= 1'b1;
            key_coord <= KEY_NONE;
        end else begin
            key_coord <= fire ? seen : KEY_NONE; // one-cycle pulse per press
            if (sample) begin
                div_cnt <= '0;
                col     <= {col[2:0], col[3]};
                if (row_q != 4'hF) begin
                    idle_cols <= '0;
                    if (armed) begin
                        cand <= seen;
                        hits <= hits_next; // a new coordinate restarts at one
                        if (fire) begin
                            armed <= 1'b0;
                        end
                    end
                end else if (idle_cols == 2'd3) begin
                    // a whole scan without any row low, key released
                    idle_cols <= '0;
                    armed     <= 1'b1;
                    hits      <= '0;
                    cand      <= KEY_NONE;
                end else begin
                    idle_cols <= idle_cols + 1'b1;
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    a_one_col_low : assert property (@(posedge clk) disable iff (!rst_n)
        $countones(~col) == 1);

endmodule

//--- src/input_unit.sv
module input_unit #(
    parameter int DATA_WIDTH = 32,
    parameter int SWITCH_CNT = 16,
    parameter int MAX_DIGITS = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  keypad_pkg::key_code_t key_coord,
    input  logic [SWITCH_CNT-1:0] switch_map,
    input  logic                  uart_complete,
    input  logic                  input_enable,
    output logic                  input_complete,
    output logic [DATA_WIDTH-1:0] input_data,
    output logic                  switch_enable,
    output logic                  cpu_pause,
    output logic                  overflow
);
    import keypad_pkg::*;

    localparam int CNT_W = $clog2(MAX_DIGITS + 1);

    input_state_t          state;
    logic [CNT_W-1:0]      digit_cnt;
    logic [DATA_WIDTH-1:0] keypad_data;
    logic                  digit_valid;
    logic [3:0]            digit_val;
    logic                  room;
    logic                  finish_key;

    // digit decode of the raw key byte
    always_comb begin
        digit_valid = 1'b1;
        digit_val   = 4'd0;
        case (key_coord.raw)
            KEY_0:        digit_val = 4'd0;
            KEY_1:        digit_val = 4'd1;
            KEY_2:        digit_val = 4'd2;
            KEY_3:        digit_val = 4'd3;
            KEY_4:        digit_val = 4'd4;
            KEY_5:        digit_val = 4'd5;
            KEY_6:        digit_val = 4'd6;
            KEY_7:        digit_val = 4'd7;
            KEY_8:        digit_val = 4'd8;
            KEY_9:        digit_val = 4'd9;
            KEY_C, KEY_D: digit_valid = 1'b0; // spare keys, no action yet
            default:      digit_valid = 1'b0;
        endcase
    end

    assign room       = (digit_cnt < CNT_W'(MAX_DIGITS));
    assign overflow   = !room;
    assign finish_key = (key_coord.raw == KEY_ENTER) || (key_coord.raw == KEY_PAUSE);

    assign input_data = switch_enable ? DATA_WIDTH'(switch_map) : keypad_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= ST_BLOCK;
            input_complete <= 1'b0;
            switch_enable  <= 1'b0;
            cpu_pause      <= 1'b0;
            digit_cnt      <= '0;
            keypad_data    <= '0;
        end else begin
            case (state)
                ST_BLOCK: begin
                    if (key_coord.raw == KEY_PAUSE) begin // pause wins over a new request
                        state     <= ST_HALT;
                        cpu_pause <= 1'b1;
                    end else if (input_enable) begin
                        state          <= ST_KEYPAD;
                        input_complete <= 1'b0;
                        keypad_data    <= '0;
                    end
                end
                ST_SWITCH, ST_KEYPAD: begin
                    if (state == ST_KEYPAD && !input_enable) begin
                        state <= ST_BLOCK; // request withdrawn
                    end else if (finish_key) begin
                        input_complete <= 1'b1;
                        digit_cnt      <= '0;
                        if (key_coord.raw == KEY_PAUSE) begin
                            state     <= ST_HALT;
                            cpu_pause <= 1'b1;
                        end else begin
                            state <= ST_BLOCK;
                        end
                    end else if (key_coord.raw == KEY_TOGGLE) begin
                        switch_enable <= (state == ST_KEYPAD);
                        state         <= (state == ST_KEYPAD) ? ST_SWITCH : ST_KEYPAD;
                    end else if (state == ST_KEYPAD) begin
                        if (key_coord.raw == KEY_BACKSPACE) begin
                            if (digit_cnt != '0) begin
                                keypad_data <= keypad_data / DATA_WIDTH'(10);
                                digit_cnt   <= digit_cnt - 1'b1;
                            end
                        end else if (digit_valid && room) begin
                            // wraps modulo 2^DATA_WIDTH
                            keypad_data <= keypad_data * DATA_WIDTH'(10) + DATA_WIDTH'(digit_val);
                            digit_cnt   <= digit_cnt + 1'b1;
                        end
                    end
                end
                ST_HALT: begin
                    if (uart_complete && key_coord.raw == KEY_PAUSE) begin
                        state     <= ST_BLOCK;
                        cpu_pause <= 1'b0;
                    end
                end
                default: state <= ST_BLOCK;
            endcase
        end
    end

    a_digit_limit : assert property (@(posedge clk) disable iff (!rst_n)
        digit_cnt <= CNT_W'(MAX_DIGITS));

    // the hazard unit sees the pause exactly while the FSM sits in halt
    a_pause_halt : assert property (@(posedge clk) disable iff (!rst_n)
        cpu_pause == (state == ST_HALT));

endmodule

//--- src/hex_display.sv
module hex_display #(
    parameter int REFRESH_DIV = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] value,
    output logic [6:0]  seg,
    output logic [3:0]  an
);
    localparam int REF_W = $clog2(REFRESH_DIV + 1);

    logic [REF_W-1:0] ref_cnt;
    logic [1:0]       digit_sel;
    logic [3:0]       nibble;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ref_cnt   <= '0;
            digit_sel <= 2'd0;
        end else if (ref_cnt == REF_W'(REFRESH_DIV - 1)) begin
            ref_cnt   <= '0;
            digit_sel <= digit_sel + 2'd1; // wraps after digit 3
        end else begin
            ref_cnt <= ref_cnt + 1'b1;
        end
    end

    assign an     = ~(4'b0001 << digit_sel);
    assign nibble = value[digit_sel*4 +: 4];

    // segment order is {g, f, e, d, c, b, a}, low means lit
    always_comb begin
        case (nibble)
            4'h0:    seg = 7'b100_0000;
            4'h1:    seg = 7'b111_1001;
            4'h2:    seg = 7'b010_0100;
            4'h3:    seg = 7'b011_0000;
            4'h4:    seg = 7'b001_1001;
            4'h5:    seg = 7'b001_0010;
            4'h6:    seg = 7'b000_0010;
            4'h7:    seg = 7'b111_1000;
            4'h8:    seg = 7'b000_0000;
            4'h9:    seg = 7'b001_0000;
            4'hA:    seg = 7'b000_1000;
            4'hB:    seg = 7'b000_0011; // lower case b
            4'hC:    seg = 7'b100_0110;
            4'hD:    seg = 7'b010_0001; // lower case d
            4'hE:    seg = 7'b000_0110;
            default: seg = 7'b000_1110;
        endcase
    end

    a_one_digit_on : assert property (@(posedge clk) disable iff (!rst_n)
        $countones(~an) == 1);

endmodule

//--- src/input_top.sv
module input_top #(
    parameter int DATA_WIDTH      = 32,
    parameter int SWITCH_CNT      = 16,
    parameter int MAX_DIGITS      = 8,
    parameter int DEBOUNCE_CYCLES = 4,
    parameter int SCAN_DIV        = 2,
    parameter int REFRESH_DIV     = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [3:0]            row,
    input  logic [SWITCH_CNT-1:0] switch_map,
    input  logic                  uart_complete,
    input  logic                  input_enable,
    output logic [3:0]            col,
    output logic                  input_complete,
    output logic [DATA_WIDTH-1:0] input_data,
    output logic                  switch_enable,
    output logic                  cpu_pause,
    output logic                  overflow,
    output logic [6:0]            seg,
    output logic [3:0]            an
);
    import keypad_pkg::*;

    key_code_t key_coord; // one-cycle key pulse, KEY_NONE when idle

    keypad_scanner #(
        .SCAN_DIV        (SCAN_DIV),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_scanner (
        .clk       (clk),
        .rst_n     (rst_n),
        .row       (row),
        .col       (col),
        .key_coord (key_coord)
    );

    input_unit #(
        .DATA_WIDTH (DATA_WIDTH),
        .SWITCH_CNT (SWITCH_CNT),
        .MAX_DIGITS (MAX_DIGITS)
    ) u_input (
        .clk            (clk),
        .rst_n          (rst_n),
        .key_coord      (key_coord),
        .switch_map     (switch_map),
        .uart_complete  (uart_complete),
        .input_enable   (input_enable),
        .input_complete (input_complete),
        .input_data     (input_data),
        .switch_enable  (switch_enable),
        .cpu_pause      (cpu_pause),
        .overflow       (overflow)
    );

    hex_display #(
        .REFRESH_DIV (REFRESH_DIV)
    ) u_display (
        .clk   (clk),
        .rst_n (rst_n),
        .value (input_data[15:0]), // only four digits fit on the board
        .seg   (seg),
        .an    (an)
    );

endmodule

//--- verif/tb_input_top.sv
module tb_input_top;
    localparam int DATA_WIDTH      = 32;
    localparam int SWITCH_CNT      = 16;
    localparam int MAX_DIGITS      = 8;
    localparam int DEBOUNCE_CYCLES = 4;
    localparam int SCAN_DIV        = 2;
    localparam int REFRESH_DIV     = 4;
    localparam int PRESS_LIMIT     = 4 * SCAN_DIV * (DEBOUNCE_CYCLES + 1) + 2;
    localparam int RELEASE_CYCLES  = 8 * SCAN_DIV + 8; // two idle scans
    localparam int M_BLOCK  = 0;
    localparam int M_SWITCH = 1;
    localparam int M_KEYPAD = 2;
    localparam int M_HALT   = 3;

    logic                  clk;
    logic                  rst_n;
    logic [3:0]            row;
    logic [SWITCH_CNT-1:0] switch_map;
    logic                  uart_complete;
    logic                  input_enable;
    logic [3:0]            col;
    logic                  input_complete;
    logic [DATA_WIDTH-1:0] input_data;
    logic                  switch_enable;
    logic                  cpu_pause;
    logic                  overflow;
    logic [6:0]            seg;
    logic [3:0]            an;

    // keypad and reference model state
    logic                  pressed;
    logic [1:0]            key_r;
    logic [1:0]            key_c;
    int                    m_state;
    logic [DATA_WIDTH-1:0] m_value;
    int                    m_cnt;
    logic                  m_complete;
    logic                  m_switch;
    logic                  m_pause;
    integer                seed;

    input_top #(
        .DATA_WIDTH      (DATA_WIDTH),
        .SWITCH_CNT      (SWITCH_CNT),
        .MAX_DIGITS      (MAX_DIGITS),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
        .SCAN_DIV        (SCAN_DIV),
        .REFRESH_DIV     (REFRESH_DIV)
    ) DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .row            (row),
        .switch_map     (switch_map),
        .uart_complete  (uart_complete),
        .input_enable   (input_enable),
        .col            (col),
        .input_complete (input_complete),
        .input_data     (input_data),
        .switch_enable  (switch_enable),
        .cpu_pause      (cpu_pause),
        .overflow       (overflow),
        .seg            (seg),
        .an             (an)
    );

    always #4 clk = ~clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("error %s expected %h actual %h", name, exp, act);
            fail_run("value mismatch");
        end
    endtask

    // one clock, then the matrix answers the column now driven
    task automatic next_cycle();
        @(negedge clk);
        if (pressed && col == ~(4'b0001 << key_c)) begin
            row = ~(4'b0001 << key_r);
        end else begin
            row = 4'hF;
        end
    endtask

    task automatic locate_key(input logic [7:0] ch);
        case (ch)
            "1": {key_r, key_c} = 4'h0;
            "2": {key_r, key_c} = 4'h1;
            "3": {key_r, key_c} = 4'h2;
            "A": {key_r, key_c} = 4'h3;
            "4": {key_r, key_c} = 4'h4;
            "5": {key_r, key_c} = 4'h5;
            "6": {key_r, key_c} = 4'h6;
            "B": {key_r, key_c} = 4'h7;
            "7": {key_r, key_c} = 4'h8;
            "8": {key_r, key_c} = 4'h9;
            "9": {key_r, key_c} = 4'hA;
            "*": {key_r, key_c} = 4'hC;
            "0": {key_r, key_c} = 4'hD;
            "#": {key_r, key_c} = 4'hE;
            default: fail_run("unknown key name in the vector file");
        endcase
    endtask

    function automatic logic [6:0] seg_pattern(input logic [3:0] n);
        logic [6:0] p; // {g..a}, low means lit
        case (n)
            4'h0: p = 7'h40;
            4'h1: p = 7'h79;
            4'h2: p = 7'h24;
            4'h3: p = 7'h30;
            4'h4: p = 7'h19;
            4'h5: p = 7'h12;
            4'h6: p = 7'h02;
            4'h7: p = 7'h78;
            4'h8: p = 7'h00;
            4'h9: p = 7'h10;
            4'hA: p = 7'h08;
            4'hB: p = 7'h03;
            4'hC: p = 7'h46;
            4'hD: p = 7'h21;
            4'hE: p = 7'h06;
            default: p = 7'h0E;
        endcase
        return p;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] expected_data();
        return m_switch ? DATA_WIDTH'(switch_map) : m_value;
    endfunction

    // returns 1 when the key finished an entry
    function automatic logic apply_key(input logic [7:0] ch);
        logic done;
        done = 1'b0;
        if (m_state == M_BLOCK) begin
            if (ch == "A") begin
                m_state = M_HALT;
                m_pause = 1'b1;
            end else if (input_enable) begin
                m_state    = M_KEYPAD;
                m_complete = 1'b0;
                m_value    = '0;
            end
        end else if (m_state == M_HALT) begin
            if (ch == "A" && uart_complete) begin
                m_state = M_BLOCK;
                m_pause = 1'b0;
            end
        end else if (m_state == M_KEYPAD && !input_enable) begin
            m_state = M_BLOCK;
        end else if (ch == "#" || ch == "A") begin
            m_complete = 1'b1;
            m_cnt      = 0;
            done       = 1'b1;
            m_state    = (ch == "A") ? M_HALT : M_BLOCK;
            m_pause    = m_pause || (ch == "A");
        end else if (ch == "B") begin
            if (m_state == M_KEYPAD) begin
                m_state  = M_SWITCH;
                m_switch = 1'b1;
            end else begin
                m_state  = M_KEYPAD;
                m_switch = 1'b0;
            end
        end else if (m_state == M_KEYPAD) begin
            if (ch == "*") begin
                if (m_cnt != 0) begin
                    m_value = m_value / 10;
                    m_cnt   = m_cnt - 1;
                end
            end else if (m_cnt < MAX_DIGITS) begin
                m_value = m_value * 10 + DATA_WIDTH'(ch - 8'h30);
                m_cnt   = m_cnt + 1;
            end
        end
        return done;
    endfunction

    task automatic press_key(input logic [7:0] ch);
        int waited;
        int hold;
        logic done;
        waited = 0;
        locate_key(ch);
        pressed = 1'b1;
        next_cycle();
        while (DUT.key_coord.raw == 8'hFF) begin
            next_cycle();
            waited++;
            if (waited > PRESS_LIMIT) fail_run("keypad scanner never reported the pressed key");
        end
        check_value("key code", {24'd0, ~(4'b0001 << key_r), ~(4'b0001 << key_c)},
                    32'(DUT.key_coord.raw));
        done = apply_key(ch);
        next_cycle(); // the input unit acts here
        if (done) begin
            input_enable = 1'b0; // the CPU takes the value and withdraws its request
        end
        hold = $random(seed) & 7;
        repeat (hold) next_cycle();
        pressed = 1'b0;
        repeat (RELEASE_CYCLES) next_cycle();
    endtask

    task automatic check_outputs(input string name);
        check_value({name, " data"}, expected_data(), input_data);
        check_value({name, " complete"}, 32'(m_complete), 32'(input_complete));
        check_value({name, " switch"}, 32'(m_switch), 32'(switch_enable));
        check_value({name, " pause"}, 32'(m_pause), 32'(cpu_pause));
        check_value({name, " overflow"}, 32'(m_cnt >= MAX_DIGITS), 32'(overflow));
    endtask

    task automatic check_display();
        logic [DATA_WIDTH-1:0] d;
        int waited;
        d = expected_data();
        for (int k = 0; k < 4; k++) begin
            waited = 0;
            while (an != ~(4'b0001 << k)) begin
                next_cycle();
                waited++;
                if (waited > 4 * REFRESH_DIV + 2) fail_run("display never selected the digit");
            end
            check_value("display seg", 32'(seg_pattern(d[k*4 +: 4])), 32'(seg));
        end
    endtask

    initial begin
        int fd;
        int n;
        int line_no;
        string line;
        logic [8*8-1:0] cmd;
        logic [8*8-1:0] arg;
        logic [31:0] val;
        clk = 1'b0;
        rst_n = 1'b0;
        row = 4'hF;
        switch_map = '0;
        uart_complete = 1'b0;
        input_enable = 1'b0;
        pressed = 1'b0;
        key_r = 2'd0;
        key_c = 2'd0;
        seed = 32'h218c_3e9d;
        m_state = M_BLOCK;
        m_value = '0;
        m_cnt = 0;
        m_complete = 1'b0;
        m_switch = 1'b0;
        m_pause = 1'b0;
        line_no = 0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        check_value("reset col", 32'hE, 32'(col));
        fd = $fopen("verif/input_vectors.txt", "r");
        if (fd == 0) fail_run("cannot open the vector file");
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line[0] == "#") continue;
            cmd = '0;
            arg = '0;
            n = $sscanf(line, "%s %s", cmd, arg);
            if (cmd == "key") begin
                press_key(arg[7:0]);
            end else if (cmd == "check") begin
                check_outputs($sformatf("line %0d", line_no));
            end else if (cmd == "disp") begin
                check_display();
            end else begin
                n = $sscanf(line, "%s %h", cmd, val);
                if (n != 2) fail_run($sformatf("vector line %0d cannot be read", line_no));
                if (cmd == "sw") begin
                    switch_map = val[SWITCH_CNT-1:0];
                end else if (cmd == "uart") begin
                    uart_complete = val[0];
                end else if (cmd == "en") begin
                    input_enable = val[0];
                    if (val[0] && m_state == M_BLOCK) begin
                        m_state    = M_KEYPAD;
                        m_complete = 1'b0;
                        m_value    = '0;
                    end else if (!val[0] && m_state == M_KEYPAD) begin
                        m_state = M_BLOCK;
                    end
                    repeat (2) next_cycle();
                end else if (cmd == "expect") begin
                    check_value($sformatf("line %0d file", line_no), val, input_data);
                    check_value($sformatf("line %0d model", line_no), expected_data(), input_data);
                end else begin
                    fail_run($sformatf("unknown command on vector line %0d", line_no));
                end
            end
        end
        $fclose(fd);
        $display("all tests passed");
        $finish;
    end

endmodule

//--- verif/input_vectors.txt
# command and argument: key <0-9 * # A B>, sw <hex>, en <0|1>, uart <0|1>
# expect <hex input_data>, check (all outputs against the model), disp (seven-segment)
check
en 1
key 1
key 2
key 3
expect 7b
key 4
key *
expect 7b
disp
key #
expect 7b
check
en 1
key *
expect 0
key 9
key 8
key 7
key 6
key 5
key 4
key 3
key 2
expect 5e30a78
key 1
expect 5e30a78
check
disp
sw abcd
key B
expect abcd
check
disp
key B
expect 5e30a78
key A
check
key A
check
uart 1
key A
check
uart 0

//--- list.f
src/keypad_pkg.sv
src/keypad_scanner.sv
src/input_unit.sv
src/hex_display.sv
src/input_top.sv
verif/tb_input_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_input_top
OBJ_DIR   ?= obj_dir
FILE_LIST ?= list.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILE_LIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILE_LIST) $(SRCS) verif/input_vectors.txt
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
